/* logic/mem_access_pkg.sv */
package mem_access_pkg;

	// One data word and one byte address.
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// One bit per byte lane, bit 0 is the lowest byte.
	typedef logic [3:0] strb_t;

	// Access width and extension of a load or store.
	typedef enum logic [2:0] {
		mode_none,
		mode_w,
		mode_h,
		mode_hu,
		mode_b,
		mode_bu
	} mem_mode_e;

	// Core-side request.
	typedef struct packed {
		addr_t addr;
		word_t wdata; // Sub-word data sits in the low bits.
		logic write;
		mem_mode_e mode;
	} mem_req_t;

	// Core-side response, rdata is zero on a store.
	typedef struct packed {
		word_t rdata;
		logic error; // Out of window, misaligned or bad store mode.
	} mem_resp_t;

endpackage

/* logic/axi_lite_pkg.sv */
package axi_lite_pkg;

	import mem_access_pkg::*;

	// Response code on the B and R channels.
	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t AXI_OKAY = 2'b00;

	// Write address channel.
	typedef struct packed {
		addr_t addr;
		logic [2:0] prot;
	} axi_aw_t;

	// Write data channel.
	typedef struct packed {
		word_t data;
		strb_t strb;
	} axi_w_t;

	// Write response channel.
	typedef struct packed {
		axi_resp_t resp;
	} axi_b_t;

	// Read address channel.
	typedef struct packed {
		addr_t addr;
		logic [2:0] prot;
	} axi_ar_t;

	// Read data channel.
	typedef struct packed {
		word_t data;
		axi_resp_t resp;
	} axi_r_t;

endpackage

/* logic/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit
	import mem_access_pkg::*;
	import axi_lite_pkg::*;
#(
	parameter addr_t BASE_ADDR = 32'h0000_0000,
	parameter int DEPTH_WORDS = 64
) (
	input logic clk,
	input logic rst,
	input mem_req_t req,
	input logic req_valid,
	output logic req_ready,
	output mem_resp_t resp,
	output logic resp_valid,
	input logic resp_ready,
	output axi_aw_t aw,
	output logic awvalid,
	input logic awready,
	output axi_w_t w,
	output logic wvalid,
	input logic wready,
	input axi_b_t b,
	input logic bvalid,
	output logic bready,
	output axi_ar_t ar,
	output logic arvalid,
	input logic arready,
	input axi_r_t r,
	input logic rvalid,
	output logic rready
);

	localparam int IDX_W = $clog2(DEPTH_WORDS);

	typedef enum logic [2:0] {
		idle,
		check,
		write_bus,
		read_bus,
		respond
	} state_e;

	state_e state;
	mem_req_t req_q;
	mem_resp_t resp_q;
	logic aw_done;
	logic w_done;
	logic ar_done;

	addr_t offset;
	logic in_range;
	logic aligned;
	logic mode_ok;
	logic legal;
	logic skip_bus;
	word_t lane_data;
	strb_t lane_strb;
	logic [15:0] half_lane;
	logic [7:0] byte_lane;
	word_t load_data;

	// Window check on the latched request.
	assign offset = req_q.addr - BASE_ADDR;
	assign in_range = (req_q.addr >= BASE_ADDR) && (offset[31:IDX_W+2] == '0);

	always_comb begin
		case (req_q.mode)
			mode_w: aligned = (req_q.addr[1:0] == 2'b00);
			mode_h, mode_hu: aligned = ~req_q.addr[0];
			default: aligned = 1'b1;
		endcase
	end

	// Stores only come in w, h and b.
	assign mode_ok = !req_q.write || (req_q.mode inside {mode_w, mode_h, mode_b});
	assign legal = in_range && aligned && mode_ok;
	assign skip_bus = !legal || (!req_q.write && req_q.mode == mode_none);

	// Data is replicated over all lanes, the strobes pick the target.
	always_comb begin
		lane_data = req_q.wdata;
		lane_strb = 4'b1111;
		case (req_q.mode)
			mode_h: begin
				lane_data = {2{req_q.wdata[15:0]}};
				lane_strb = req_q.addr[1] ? 4'b1100 : 4'b0011;
			end
			mode_b: begin
				lane_data = {4{req_q.wdata[7:0]}};
				lane_strb = 4'b0001 << req_q.addr[1:0];
			end
			default: ;
		endcase
	end

	assign half_lane = req_q.addr[1] ? r.data[31:16] : r.data[15:0];
	assign byte_lane = r.data[{req_q.addr[1:0], 3'b000} +: 8];

	always_comb begin
		case (req_q.mode)
			mode_w: load_data = r.data;
			mode_h: load_data = {{16{half_lane[15]}}, half_lane};
			mode_hu: load_data = {16'b0, half_lane};
			mode_b: load_data = {{24{byte_lane[7]}}, byte_lane};
			mode_bu: load_data = {24'b0, byte_lane};
			default: load_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			aw_done <= 1'b0;
			w_done <= 1'b0;
			ar_done <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (req_valid)
						state <= check;
				end
				check: begin
					aw_done <= 1'b0;
					w_done <= 1'b0;
					ar_done <= 1'b0;
					if (skip_bus)
						state <= respond;
					else if (req_q.write)
						state <= write_bus;
					else
						state <= read_bus;
				end
				write_bus: begin
					if (awvalid && awready)
						aw_done <= 1'b1;
					if (wvalid && wready)
						w_done <= 1'b1;
					if (bvalid && bready)
						state <= respond;
				end
				read_bus: begin
					if (arvalid && arready)
						ar_done <= 1'b1;
					if (rvalid && rready)
						state <= respond;
				end
				respond: begin
					if (resp_ready)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && req_valid)
			req_q <= req;
		if (state == check && skip_bus) begin
			resp_q.rdata <= '0;
			resp_q.error <= !legal;
		end
		if (state == write_bus && bvalid && bready) begin
			resp_q.rdata <= '0;
			resp_q.error <= (b.resp != AXI_OKAY);
		end
		if (state == read_bus && rvalid && rready) begin
			resp_q.rdata <= load_data;
			resp_q.error <= (r.resp != AXI_OKAY);
		end
	end

	assign req_ready = (state == idle);
	assign resp = resp_q;
	assign resp_valid = (state == respond);

	// Bus addresses are window offsets.
	assign aw.addr = {offset[31:2], 2'b00};
	assign aw.prot = 3'b000;
	assign awvalid = (state == write_bus) && !aw_done;
	assign w.data = lane_data;
	assign w.strb = lane_strb;
	assign wvalid = (state == write_bus) && !w_done;
	assign bready = (state == write_bus);
	assign ar.addr = {offset[31:2], 2'b00};
	assign ar.prot = 3'b000;
	assign arvalid = (state == read_bus) && !ar_done;
	assign rready = (state == read_bus);

	// Core must hold a waiting request.
	req_hold: assert property (@(posedge clk) disable iff (rst)
		req_valid && !req_ready |=> req_valid && $stable(req));

	aw_with_w: assert property (@(posedge clk) disable iff (rst)
		$rose(awvalid) |-> wvalid);

endmodule

/* logic/axi_lite_ram.sv */
`timescale 1ns/1ps

module axi_lite_ram
	import mem_access_pkg::*;
	import axi_lite_pkg::*;
#(
	parameter int DEPTH_WORDS = 64
) (
	input logic clk,
	input logic rst,
	input axi_aw_t aw,
	input logic awvalid,
	output logic awready,
	input axi_w_t w,
	input logic wvalid,
	output logic wready,
	output axi_b_t b,
	output logic bvalid,
	input logic bready,
	input axi_ar_t ar,
	input logic arvalid,
	output logic arready,
	output axi_r_t r,
	output logic rvalid,
	input logic rready
);

	localparam int IDX_W = $clog2(DEPTH_WORDS);

	typedef logic [IDX_W-1:0] idx_t;

	word_t mem [DEPTH_WORDS];
	idx_t wr_idx;
	idx_t rd_idx;
	logic wr_fire;
	logic rd_fire;
	logic bvalid_q;
	logic rvalid_q;
	word_t rdata_q;

	// Word index from the bits above the byte offset.
	assign wr_idx = aw.addr[IDX_W+1:2];
	assign rd_idx = ar.addr[IDX_W+1:2];

	assign awready = !bvalid_q;
	assign wready = !bvalid_q;
	assign arready = !rvalid_q;

	assign wr_fire = awvalid && awready && wvalid && wready;
	assign rd_fire = arvalid && arready;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_fire) begin
			for (int i = 0; i < 4; i++) begin
				if (w.strb[i])
					mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid_q <= 1'b0;
		end else begin
			if (wr_fire)
				bvalid_q <= 1'b1;
			else if (bready)
				bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid_q <= 1'b0;
		end else begin
			if (rd_fire)
				rvalid_q <= 1'b1;
			else if (rready)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata_q <= mem[rd_idx]; // Old word on a same-edge write.
	end

	assign b.resp = AXI_OKAY;
	assign bvalid = bvalid_q;
	assign r.data = rdata_q;
	assign r.resp = AXI_OKAY;
	assign rvalid = rvalid_q;

	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid);

	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(r));

endmodule

/* logic/data_memory_top.sv */
`timescale 1ns/1ps

module data_memory_top
	import mem_access_pkg::*;
	import axi_lite_pkg::*;
#(
	parameter addr_t BASE_ADDR = 32'h0000_2000,
	parameter int DEPTH_WORDS = 64
) (
	input logic clk,
	input logic rst,
	input mem_req_t req,
	input logic req_valid,
	output logic req_ready,
	output mem_resp_t resp,
	output logic resp_valid,
	input logic resp_ready
);

	// AXI4-Lite link.
	axi_aw_t aw;
	logic awvalid;
	logic awready;
	axi_w_t w;
	logic wvalid;
	logic wready;
	axi_b_t b;
	logic bvalid;
	logic bready;
	axi_ar_t ar;
	logic arvalid;
	logic arready;
	axi_r_t r;
	logic rvalid;
	logic rready;

	load_store_unit #(
		.BASE_ADDR(BASE_ADDR),
		.DEPTH_WORDS(DEPTH_WORDS)
	) lsu_i (
		.clk(clk), .rst(rst),
		.req(req), .req_valid(req_valid), .req_ready(req_ready),
		.resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready)
	);

	axi_lite_ram #(
		.DEPTH_WORDS(DEPTH_WORDS)
	) ram_i (
		.clk(clk), .rst(rst),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready)
	);

endmodule

/* verification/data_memory_tests.svh */
task automatic test_word_store_load();
	int errs;
	addr_t a;
	errs = error_count;
	for (int i = 0; i < 7; i++) begin
		a = BASE_ADDR + 4 * ((i * 11) % DEPTH_WORDS);
		if (i == 6)
			a = BASE_ADDR + 4 * (DEPTH_WORDS - 1); // Last word.
		access_and_check(make_req(1'b1, mode_w, a, lfsr_bits(32)));
		access_and_check(make_req(1'b0, mode_w, a, '0));
	end
	report_test("word_store_load", errs);
endtask

task automatic test_lane_merge();
	int errs;
	addr_t a;
	errs = error_count;
	a = BASE_ADDR + 32'h40;
	access_and_check(make_req(1'b1, mode_w, a, 32'h1122_3344));
	access_and_check(make_req(1'b1, mode_b, a + 1, 32'hffff_ffab));
	access_and_check(make_req(1'b1, mode_h, a + 2, 32'h1234_cdef));
	access_and_check(make_req(1'b0, mode_w, a, '0));
	check_word("resp.rdata", last_resp.rdata, 32'hcdef_ab44);

	a = BASE_ADDR + 32'h44;
	access_and_check(make_req(1'b1, mode_w, a, 32'ha5a5_a5a5));
	access_and_check(make_req(1'b1, mode_h, a, 32'h0000_5a5a));
	access_and_check(make_req(1'b1, mode_b, a + 3, 32'h0000_003c));
	access_and_check(make_req(1'b0, mode_w, a, '0));
	check_word("resp.rdata", last_resp.rdata, 32'h3ca5_5a5a);
	report_test("lane_merge", errs);
endtask

task automatic test_load_extend();
	int errs;
	addr_t a;
	word_t patterns [2];
	errs = error_count;
	patterns[0] = 32'h80ff_7f01;
	patterns[1] = 32'h7f80_01ff;
	a = BASE_ADDR + 32'h80;
	for (int p = 0; p < 2; p++) begin
		access_and_check(make_req(1'b1, mode_w, a, patterns[p]));
		for (int off = 0; off < 4; off++) begin
			access_and_check(make_req(1'b0, mode_b, a + off, '0));
			access_and_check(make_req(1'b0, mode_bu, a + off, '0));
		end
		for (int off = 0; off < 4; off += 2) begin
			access_and_check(make_req(1'b0, mode_h, a + off, '0));
			access_and_check(make_req(1'b0, mode_hu, a + off, '0));
		end
	end
	// Low byte 0xff, so bu and b must differ.
	access_and_check(make_req(1'b0, mode_b, a, '0));
	check_word("resp.rdata", last_resp.rdata, 32'hffff_ffff);
	access_and_check(make_req(1'b0, mode_none, a + 1, '0));
	check_word("resp.rdata", last_resp.rdata, 32'h0000_0000);
	report_test("load_extend", errs);
endtask

task automatic test_illegal();
	int errs;
	addr_t a;
	addr_t top;
	mem_req_t bad [$];
	errs = error_count;
	a = BASE_ADDR + 32'hc0;
	top = BASE_ADDR + 4 * DEPTH_WORDS;
	access_and_check(make_req(1'b1, mode_w, a, 32'hdead_beef));
	bad.push_back(make_req(1'b1, mode_w, a + 1, 32'h0bad_f00d));
	bad.push_back(make_req(1'b1, mode_w, a + 2, 32'h0bad_f00d));
	bad.push_back(make_req(1'b0, mode_w, a + 3, '0));
	bad.push_back(make_req(1'b1, mode_h, a + 1, 32'h0bad_f00d));
	bad.push_back(make_req(1'b0, mode_hu, a + 3, '0));
	bad.push_back(make_req(1'b0, mode_w, BASE_ADDR - 4, '0));
	bad.push_back(make_req(1'b1, mode_w, BASE_ADDR - 4, 32'h0bad_f00d));
	bad.push_back(make_req(1'b0, mode_b, BASE_ADDR - 1, '0));
	bad.push_back(make_req(1'b1, mode_w, top, 32'h0bad_f00d));
	bad.push_back(make_req(1'b0, mode_b, top, '0));
	bad.push_back(make_req(1'b1, mode_hu, a, 32'h0bad_f00d));
	bad.push_back(make_req(1'b1, mode_bu, a, 32'h0bad_f00d));
	bad.push_back(make_req(1'b1, mode_none, a, 32'h0bad_f00d));
	foreach (bad[i]) begin
		access_and_check(bad[i]);
		check_error("resp.error", last_resp.error, 1'b1);
	end
	access_and_check(make_req(1'b0, mode_w, a, '0));
	check_word("resp.rdata", last_resp.rdata, 32'hdead_beef);
	// Wrapped writes would land in the first or last word.
	access_and_check(make_req(1'b0, mode_w, BASE_ADDR, '0));
	access_and_check(make_req(1'b0, mode_w, top - 4, '0));
	report_test("illegal", errs);
endtask

task automatic test_backpressure();
	int errs;
	addr_t a;
	mem_resp_t held;
	errs = error_count;
	a = BASE_ADDR + 32'h10;
	access_and_check(make_req(1'b1, mode_w, a, 32'h5566_7788));
	resp_ready = 1'b0;
	send_req(make_req(1'b0, mode_w, a, '0));
	wait_resp(held);
	check_word("resp.rdata", held.rdata, model_load(a, mode_w));
	check_error("resp.error", held.error, 1'b0);
	repeat (6) begin
		@(negedge clk);
		check_error("resp_valid", resp_valid, 1'b1);
		check_error("req_ready", req_ready, 1'b0);
		check_word("resp.rdata", resp.rdata, held.rdata);
		check_error("resp.error", resp.error, held.error);
	end
	resp_ready = 1'b1;
	@(negedge clk);
	access_and_check(make_req(1'b1, mode_b, a + 2, 32'h0000_0099));
	access_and_check(make_req(1'b0, mode_w, a, '0));
	report_test("backpressure", errs);
endtask

task automatic test_random();
	int errs;
	logic write;
	mem_mode_e mode;
	word_t idx;
	word_t off;
	errs = error_count;
	for (int i = 0; i < 80; i++) begin
		write = 1'(lfsr_bits(1));
		if (write)
			mode = mem_mode_e'(3'(lfsr_bits(2) % 3 * 2 + 1)); // Picks w, hu, bu.
		else
			mode = mem_mode_e'(3'(lfsr_bits(3) % 6));
		if (write && mode == mode_hu)
			mode = mode_h;
		else if (write && mode == mode_bu)
			mode = mode_b;
		idx = lfsr_bits(6);
		off = lfsr_bits(2);
		if (mode == mode_w)
			off = 0;
		else if (mode == mode_h || mode == mode_hu)
			off = off & 2;
		access_and_check(make_req(write, mode, BASE_ADDR + (idx << 2) + off, lfsr_bits(32)));
	end
	report_test("random", errs);
endtask

/* verification/data_memory_tb.sv */
`timescale 1ns/1ps

module data_memory_tb
	import mem_access_pkg::*;
();

	localparam addr_t BASE_ADDR = 32'h0000_2000;
	localparam int DEPTH_WORDS = 64;
	localparam int TIMEOUT = 50; // Cycles per wait.

	logic clk = 1'b0;
	logic rst;
	mem_req_t req;
	logic req_valid;
	logic req_ready;
	mem_resp_t resp;
	logic resp_valid;
	logic resp_ready;

	word_t ref_mem [DEPTH_WORDS];
	word_t lfsr_state = 32'h874c5278;
	mem_resp_t last_resp;
	int test_count = 0;
	int check_count = 0;
	int error_count = 0;

	data_memory_top #(
		.BASE_ADDR(BASE_ADDR),
		.DEPTH_WORDS(DEPTH_WORDS)
	) dut_i (
		.clk(clk), .rst(rst),
		.req(req), .req_valid(req_valid), .req_ready(req_ready),
		.resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready)
	);

	always #50 clk = ~clk;

	// Taps 32, 22, 2, 1.
	function automatic word_t lfsr_bits(input int n);
		word_t v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic mem_req_t make_req(input logic write, input mem_mode_e mode,
			input addr_t addr, input word_t data);
		mem_req_t rq;
		rq.addr = addr;
		rq.wdata = data;
		rq.write = write;
		rq.mode = mode;
		return rq;
	endfunction

	function automatic logic is_legal(input mem_req_t rq);
		logic in_win;
		logic align_ok;
		logic store_ok;
		in_win = (rq.addr >= BASE_ADDR) && (rq.addr <= BASE_ADDR + 4 * DEPTH_WORDS - 1);
		align_ok = 1'b1;
		if (rq.mode == mode_w)
			align_ok = (rq.addr[1:0] == 2'b00);
		else if (rq.mode == mode_h || rq.mode == mode_hu)
			align_ok = !rq.addr[0];
		store_ok = !rq.write || rq.mode == mode_w || rq.mode == mode_h || rq.mode == mode_b;
		return in_win && align_ok && store_ok;
	endfunction

	function automatic word_t model_load(input addr_t addr, input mem_mode_e mode);
		addr_t off;
		word_t wd;
		logic [15:0] h16;
		logic [7:0] b8;
		off = addr - BASE_ADDR;
		wd = ref_mem[off[31:2]];
		h16 = 16'(wd >> (16 * addr[1]));
		b8 = 8'(wd >> (8 * addr[1:0]));
		case (mode)
			mode_w: return wd;
			mode_h: return {{16{h16[15]}}, h16};
			mode_hu: return {16'h0000, h16};
			mode_b: return {{24{b8[7]}}, b8};
			mode_bu: return {24'h000000, b8};
			default: return '0;
		endcase
	endfunction

	function automatic void model_store(input addr_t addr, input word_t data,
			input mem_mode_e mode);
		addr_t off;
		off = addr - BASE_ADDR;
		if (mode == mode_w)
			ref_mem[off[31:2]] = data;
		else if (mode == mode_h)
			ref_mem[off[31:2]][16 * addr[1] +: 16] = data[15:0];
		else if (mode == mode_b)
			ref_mem[off[31:2]][8 * addr[1:0] +: 8] = data[7:0];
	endfunction

	task automatic stop_on_timeout(input string what);
		$display("Timeout: %s never came within %0d cycles", what, TIMEOUT);
		$display("Finished with errors");
		$finish;
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_error(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Called on a falling edge, returns on the falling edge after acceptance.
	task automatic send_req(input mem_req_t rq);
		int cycles;
		req = rq;
		req_valid = 1'b1;
		cycles = 0;
		while (!req_ready && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!req_ready)
			stop_on_timeout("req_ready");
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic wait_resp(output mem_resp_t rsp);
		int cycles;
		cycles = 0;
		while (!resp_valid && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!resp_valid)
			stop_on_timeout("resp_valid");
		rsp = resp;
	endtask

	task automatic access_and_check(input mem_req_t rq);
		mem_resp_t exp;
		exp.error = !is_legal(rq);
		exp.rdata = '0;
		if (!exp.error && !rq.write)
			exp.rdata = model_load(rq.addr, rq.mode);
		send_req(rq);
		wait_resp(last_resp);
		@(negedge clk); // Taken on the edge before.
		check_word("resp.rdata", last_resp.rdata, exp.rdata);
		check_error("resp.error", last_resp.error, exp.error);
		if (!exp.error && rq.write)
			model_store(rq.addr, rq.wdata, rq.mode);
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		$display("Test %s done, %0d errors", name, error_count - errs_before);
	endtask

	`include "data_memory_tests.svh"

	initial begin
		rst = 1'b1;
		req = '0;
		req_valid = 1'b0;
		resp_ready = 1'b1;
		for (int i = 0; i < DEPTH_WORDS; i++)
			ref_mem[i] = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_word_store_load();
		test_lane_merge();
		test_load_extend();
		test_illegal();
		test_backpressure();
		test_random();

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+verification
logic/mem_access_pkg.sv
logic/axi_lite_pkg.sv
logic/load_store_unit.sv
logic/axi_lite_ram.sv
logic/data_memory_top.sv
verification/data_memory_tb.sv

/* Bender.yml */
package:
  name: data_memory

sources:
  - files:
      - logic/mem_access_pkg.sv
      - logic/axi_lite_pkg.sv
      - logic/load_store_unit.sv
      - logic/axi_lite_ram.sv
      - logic/data_memory_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/data_memory_tb.sv
